// ==== Makefile ====
# Verilator flow for the Ethernet MAC host glue

TOP = tbEth

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f ethHost.f

sim:
	verilator --binary --timing --top-module $(TOP) -f ethHost.f -o simEth
	@out="$$(./obj_dir/simEth)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== busDecode.sv ====
/*
 * Host bus address decoder
 * Splits the 4 KB slave space into register, descriptor and miss regions
 * and turns each request into byte-lane selects or an error request
 */

`timescale 1ns/1ps

module busDecode (
  input  logic             ifpins,
  input  logic             rstN_i,
  input  logic             stb_i,
  input  logic             cyc_i,
  input  ethPkg::wordAddrT adr_i,
  input  ethPkg::byteSelT  sel_i,
  output ethPkg::byteSelT  regCs_o,
  output logic             errReq_o,
  output ethPkg::regIdxT   regIdx_o
);

  // Clock and reset only keep the header uniform
  // The decode itself is purely combinational

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  // Region code sits in address bits 11:10
  // 0x000 - 0x3FF registers
  localparam logic [1:0] RegRegion  = 2'b00;
  // 0x400 - 0x7FF descriptors, no longer backed
  localparam logic [1:0] DescRegion = 2'b01;
  // 0x800 - 0xFFF is the miss region, bit 11 alone marks it

  logic request;
  logic byteSelected;
  logic regRegion;
  logic descRegion;
  logic missRegion;

  // Valid bus cycle
  assign request = stb_i & cyc_i;

  // At least one lane enabled
  assign byteSelected = |sel_i;

  // Region hits
  assign regRegion  = (adr_i[11:10] == RegRegion);
  assign descRegion = (adr_i[11:10] == DescRegion);
  assign missRegion = adr_i[11];

  ////////////////////////////////////////////////////////////////////////////
  // Selects and error
  ////////////////////////////////////////////////////////////////////////////

  // One select per lane, only inside the register region
  assign regCs_o = {$bits(sel_i){request & byteSelected & regRegion}} & sel_i;

  // No lane selected, or an address with nothing behind it
  // Descriptor region answers like the miss region
  assign errReq_o = request & (~byteSelected | descRegion | missRegion);

  // Word index within the register region
  assign regIdx_o = adr_i[9:2];

endmodule

// ==== ethHost.f ====
ethPkg.sv
busDecode.sv
phySync.sv
ethRegs.sv
ethHost.sv
tbEthChecker.sv
tbEth.sv

// ==== ethHost.sv ====
/*
 * Ethernet MAC host glue top level
 * Bus decoder, PHY status front end and register file
 */

`timescale 1ns/1ps

module ethHost #(
  parameter int SyncStages = 2
) (
  input  logic             ifpins,
  input  logic             rstN_i,
  // Host slave bus
  input  logic             stb_i,
  input  logic             cyc_i,
  input  logic             we_i,
  input  ethPkg::wordAddrT adr_i,
  input  ethPkg::byteSelT  sel_i,
  input  ethPkg::dataT     dat_i,
  output ethPkg::dataT     dat_o,
  output logic             ack_o,
  output logic             err_o,
  output logic             int_o,
  // PHY receive side
  input  logic             crs_i,
  input  logic             coll_i,
  input  logic             rxDv_i,
  input  logic             rxErr_i,
  input  ethPkg::nibbleT   rxD_i,
  output logic             rxDvGated_o,
  output logic             rxErrGated_o,
  output ethPkg::nibbleT   rxDGated_o
);

  import ethPkg::*;

  // Decoder to register file
  byteSelT regCs;
  logic    errReq;
  regIdxT  regIdx;

  // PHY front end to register file
  logic carrier;
  logic collision;
  logic rxEnActive;
  logic collEvent;
  logic frameStart;

  // Mode bits back to the PHY front end
  logic rxEnReq;
  logic fullD;

  ////////////////////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////////////////////

  busDecode decode (
    .ifpins   (ifpins),
    .rstN_i   (rstN_i),
    .stb_i    (stb_i),
    .cyc_i    (cyc_i),
    .adr_i    (adr_i),
    .sel_i    (sel_i),
    .regCs_o  (regCs),
    .errReq_o (errReq),
    .regIdx_o (regIdx)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PHY front end
  ////////////////////////////////////////////////////////////////////////////

  phySync #(
    .SyncStages (SyncStages)
  ) phy (
    .ifpins       (ifpins),
    .rstN_i       (rstN_i),
    .crs_i        (crs_i),
    .coll_i       (coll_i),
    .rxDv_i       (rxDv_i),
    .rxErr_i      (rxErr_i),
    .rxD_i        (rxD_i),
    .rxEnReq_i    (rxEnReq),
    .fullD_i      (fullD),
    .carrier_o    (carrier),
    .collision_o  (collision),
    .rxEnActive_o (rxEnActive),
    .rxDvGated_o  (rxDvGated_o),
    .rxErrGated_o (rxErrGated_o),
    .rxDGated_o   (rxDGated_o),
    .collEvent_o  (collEvent),
    .frameStart_o (frameStart)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  ethRegs regs (
    .ifpins       (ifpins),
    .rstN_i       (rstN_i),
    .we_i         (we_i),
    .dat_i        (dat_i),
    .regCs_i      (regCs),
    .errReq_i     (errReq),
    .regIdx_i     (regIdx),
    .carrier_i    (carrier),
    .collision_i  (collision),
    .rxEnActive_i (rxEnActive),
    .collEvent_i  (collEvent),
    .frameStart_i (frameStart),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .err_o        (err_o),
    .int_o        (int_o),
    .rxEnReq_o    (rxEnReq),
    .fullD_o      (fullD)
  );

endmodule

// ==== ethPkg.sv ====
/*
 * Ethernet MAC host glue shared definitions
 * Bus widths, register map and register bit fields
 */

package ethPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and PHY widths
  ////////////////////////////////////////////////////////////////////////////

  // Host bus data word
  typedef logic [31:0] dataT;
  // Word address, byte offset bits dropped
  typedef logic [11:2] wordAddrT;
  // One select per byte lane
  typedef logic [3:0] byteSelT;
  // Register index inside the register region
  typedef logic [7:0] regIdxT;
  // MII receive nibble
  typedef logic [3:0] nibbleT;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  // Byte addresses
  localparam logic [11:0] ModerAdr     = 12'h000;
  localparam logic [11:0] IntSourceAdr = 12'h004;
  localparam logic [11:0] IntMaskAdr   = 12'h008;
  localparam logic [11:0] StatusAdr    = 12'h00C;
  localparam logic [11:0] MacAddr0Adr  = 12'h040;
  localparam logic [11:0] MacAddr1Adr  = 12'h044;

  // Same registers as word indexes
  localparam regIdxT ModerIdx     = ModerAdr[9:2];
  localparam regIdxT IntSourceIdx = IntSourceAdr[9:2];
  localparam regIdxT IntMaskIdx   = IntMaskAdr[9:2];
  localparam regIdxT StatusIdx    = StatusAdr[9:2];
  localparam regIdxT MacAddr0Idx  = MacAddr0Adr[9:2];
  localparam regIdxT MacAddr1Idx  = MacAddr1Adr[9:2];

  ////////////////////////////////////////////////////////////////////////////
  // Bit fields
  ////////////////////////////////////////////////////////////////////////////

  // MODER
  localparam int ModerRxEnBit  = 0;
  localparam int ModerFullDBit = 10;
  localparam int ModerWidth    = 17;
  // INT_SOURCE and INT_MASK share one layout
  localparam int IntCollBit  = 0;
  localparam int IntFrameBit = 1;
  localparam int IntWidth    = 2;
  // STATUS
  localparam int StatCarrierBit = 0;
  localparam int StatCollBit    = 1;
  localparam int StatRxEnBit    = 2;
  // Upper MAC address half
  localparam int MacAddr1Width = 16;

  // Stored bits of each register as seen on the bus
  localparam dataT ModerMask    = 32'h0001_FFFF;
  localparam dataT IntBitsMask  = 32'h0000_0003;
  localparam dataT StatusMask   = 32'h0000_0007;
  localparam dataT MacAddr1Mask = 32'h0000_FFFF;

  // All registers come out of reset cleared
  localparam dataT RegResetVal = '0;

endpackage

// ==== ethRegs.sv ====
/*
 * Ethernet MAC host register file
 * Mode, interrupt, status and MAC address registers with byte-lane writes,
 * a registered single-cycle bus response and the interrupt output
 */

`timescale 1ns/1ps

module ethRegs (
  input  logic            ifpins,
  input  logic            rstN_i,
  input  logic            we_i,
  input  ethPkg::dataT    dat_i,
  input  ethPkg::byteSelT regCs_i,
  input  logic            errReq_i,
  input  ethPkg::regIdxT  regIdx_i,
  input  logic            carrier_i,
  input  logic            collision_i,
  input  logic            rxEnActive_i,
  input  logic            collEvent_i,
  input  logic            frameStart_i,
  output ethPkg::dataT    dat_o,
  output logic            ack_o,
  output logic            err_o,
  output logic            int_o,
  output logic            rxEnReq_o,
  output logic            fullD_o
);

  import ethPkg::*;

  // Stored registers
  logic [ModerWidth-1:0]    moder;
  logic [IntWidth-1:0]      intSource;
  logic [IntWidth-1:0]      intMask;
  dataT                     macAddr0;
  logic [MacAddr1Width-1:0] macAddr1;

  // Registered bus response
  logic ackQ;
  logic errQ;
  dataT datQ;

  // Write decode
  logic wrAccess;
  logic moderWr;
  logic intSourceWr;
  logic intMaskWr;
  logic macAddr0Wr;
  logic macAddr1Wr;

  // Merged write values
  dataT moderNext;
  dataT intMaskNext;
  dataT macAddr0Next;
  dataT macAddr1Next;

  // Interrupt source update
  logic [IntWidth-1:0] intSet;
  logic [IntWidth-1:0] intClr;

  // Read path
  dataT statusWord;
  dataT regMux;
  dataT readData;

  // Replace only the selected byte lanes
  function automatic dataT laneMerge(input dataT oldVal, input dataT newVal,
                                     input byteSelT lanes);
    dataT result;
    result = oldVal;
    for (int i = 0; i < $bits(byteSelT); i++)
    begin
      if (lanes[i])
        result[8*i +: 8] = newVal[8*i +: 8];
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  // One write per acknowledge, a held request skips the off cycle
  assign wrAccess = we_i & (|regCs_i) & ~ackQ;

  assign moderWr     = wrAccess & (regIdx_i == ModerIdx);
  assign intSourceWr = wrAccess & (regIdx_i == IntSourceIdx);
  assign intMaskWr   = wrAccess & (regIdx_i == IntMaskIdx);
  assign macAddr0Wr  = wrAccess & (regIdx_i == MacAddr0Idx);
  assign macAddr1Wr  = wrAccess & (regIdx_i == MacAddr1Idx);
  // STATUS and unmapped indexes take no write

  assign moderNext    = laneMerge(dataT'(moder), dat_i, regCs_i);
  assign intMaskNext  = laneMerge(dataT'(intMask), dat_i, regCs_i);
  assign macAddr0Next = laneMerge(macAddr0, dat_i, regCs_i);
  assign macAddr1Next = laneMerge(dataT'(macAddr1), dat_i, regCs_i);

  // Event bits into INT_SOURCE
  always_comb
  begin
    intSet              = '0;
    intSet[IntCollBit]  = collEvent_i;
    intSet[IntFrameBit] = frameStart_i;
  end

  // Write 1 to clear, all source bits live in lane 0
  assign intClr = (intSourceWr & regCs_i[0]) ? dat_i[IntWidth-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ifpins)
  begin
    if (!rstN_i)
    begin
      moder     <= RegResetVal[ModerWidth-1:0];
      intSource <= RegResetVal[IntWidth-1:0];
      intMask   <= RegResetVal[IntWidth-1:0];
      macAddr0  <= RegResetVal;
      macAddr1  <= RegResetVal[MacAddr1Width-1:0];
    end
    else
    begin
      if (moderWr)
        moder <= moderNext[ModerWidth-1:0];
      if (intMaskWr)
        intMask <= intMaskNext[IntWidth-1:0];
      if (macAddr0Wr)
        macAddr0 <= macAddr0Next;
      if (macAddr1Wr)
        macAddr1 <= macAddr1Next[MacAddr1Width-1:0];
      // A new event beats a clear in the same cycle
      intSource <= (intSource & ~intClr) | intSet;
    end
  end

  // Mode bits toward the PHY front end
  assign rxEnReq_o = moder[ModerRxEnBit];
  assign fullD_o   = moder[ModerFullDBit];

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    statusWord                 = '0;
    statusWord[StatCarrierBit] = carrier_i;
    statusWord[StatCollBit]    = collision_i;
    statusWord[StatRxEnBit]    = rxEnActive_i;
  end

  always_comb
  begin
    case (regIdx_i)
      ModerIdx:     regMux = dataT'(moder);
      IntSourceIdx: regMux = dataT'(intSource);
      IntMaskIdx:   regMux = dataT'(intMask);
      StatusIdx:    regMux = statusWord;
      MacAddr0Idx:  regMux = macAddr0;
      MacAddr1Idx:  regMux = dataT'(macAddr1);
      default:      regMux = '0;
    endcase
  end

  // Data only for register reads
  assign readData = ((|regCs_i) & ~we_i) ? regMux : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Bus response
  ////////////////////////////////////////////////////////////////////////////

  // Forced low after each pulse, a held request alternates
  always_ff @(posedge ifpins)
  begin
    if (!rstN_i)
    begin
      ackQ <= 1'b0;
      errQ <= 1'b0;
    end
    else
    begin
      ackQ <= (|regCs_i) & ~ackQ;
      errQ <= errReq_i & ~errQ;
    end
  end

  // Read data lines up with the acknowledge
  always_ff @(posedge ifpins)
  begin
    datQ <= readData;
  end

  assign ack_o = ackQ;
  assign err_o = errQ;
  assign dat_o = datQ;

  // Level interrupt from unmasked sources
  assign int_o = |(intSource & intMask);

endmodule

// ==== phySync.sv ====
/*
 * PHY status front end
 * Synchronizes carrier sense and collision, gates the receive path
 * with a frame-safe receive enable and flags collision and frame start
 */

`timescale 1ns/1ps

module phySync #(
  parameter int SyncStages = 2
) (
  input  logic           ifpins,
  input  logic           rstN_i,
  input  logic           crs_i,
  input  logic           coll_i,
  input  logic           rxDv_i,
  input  logic           rxErr_i,
  input  ethPkg::nibbleT rxD_i,
  input  logic           rxEnReq_i,
  input  logic           fullD_i,
  output logic           carrier_o,
  output logic           collision_o,
  output logic           rxEnActive_o,
  output logic           rxDvGated_o,
  output logic           rxErrGated_o,
  output ethPkg::nibbleT rxDGated_o,
  output logic           collEvent_o,
  output logic           frameStart_o
);

  // Synchronizer chains, index 0 samples the pin
  logic [SyncStages-1:0] crsSync;
  logic [SyncStages-1:0] collSync;

  // Receive enable as seen by the PHY path
  logic rxEnActive;

  // Previous values for the edge detectors
  logic collPrev;
  logic dvGatedPrev;

  ////////////////////////////////////////////////////////////////////////////
  // Carrier sense and collision
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ifpins)
  begin
    if (!rstN_i)
    begin
      crsSync  <= '0;
      collSync <= '0;
    end
    else
    begin
      crsSync  <= {crsSync[SyncStages-2:0], crs_i};
      collSync <= {collSync[SyncStages-2:0], coll_i};
    end
  end

  // Both are meaningless in full duplex
  assign carrier_o   = crsSync[SyncStages-1] & ~fullD_i;
  assign collision_o = collSync[SyncStages-1] & ~fullD_i;

  ////////////////////////////////////////////////////////////////////////////
  // Receive enable and gating
  ////////////////////////////////////////////////////////////////////////////

  // Only follow the request between frames
  // so a frame is never cut in half
  always_ff @(posedge ifpins)
  begin
    if (!rstN_i)
      rxEnActive <= 1'b0;
    else if (!rxDv_i)
      rxEnActive <= rxEnReq_i;
  end

  assign rxEnActive_o = rxEnActive;

  // Gated receive path toward the MAC
  assign rxDvGated_o  = rxDv_i & rxEnActive;
  assign rxErrGated_o = rxErr_i & rxEnActive;
  // Nibble is qualified by data valid downstream
  assign rxDGated_o   = rxD_i;

  ////////////////////////////////////////////////////////////////////////////
  // Event pulses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ifpins)
  begin
    if (!rstN_i)
    begin
      collPrev    <= 1'b0;
      dvGatedPrev <= 1'b0;
    end
    else
    begin
      collPrev    <= collision_o;
      dvGatedPrev <= rxDvGated_o;
    end
  end

  // Rising edges, one cycle wide
  assign collEvent_o  = collision_o & ~collPrev;
  assign frameStart_o = rxDvGated_o & ~dvGatedPrev;

endmodule

// ==== tbEth.sv ====
/*
 * Testbench for the Ethernet MAC host glue
 * Drives the host bus and PHY pins, checks gating, status and interrupts
 */

`timescale 1ns/1ps

module tbEth;

  import ethPkg::*;

  localparam int SyncStages = 2;
  // Falling edges allowed before a bus access counts as lost
  localparam int BusTimeout = 50;

  logic     ifpins;
  logic     rstN;
  // Host bus
  logic     stb;
  logic     cyc;
  logic     we;
  wordAddrT adr;
  byteSelT  sel;
  dataT     datIn;
  dataT     datOut;
  logic     ack;
  logic     err;
  logic     intr;
  // PHY pins
  logic     crs;
  logic     coll;
  logic     rxDv;
  logic     rxErr;
  nibbleT   rxD;
  logic     rxDvGated;
  logic     rxErrGated;
  nibbleT   rxDGated;

  // Values the checker cannot see from the bus alone
  dataT  expStatus;
  dataT  expIntSrc;
  int    chkErrors;
  int    tbErrors = 0;
  string testName = "";

  logic [31:0] lfsrState = 32'he532b109;
  logic [11:0] errAdr;
  logic [11:0] laneRegs [4] = '{ModerAdr, IntMaskAdr, MacAddr0Adr, MacAddr1Adr};
  logic [11:0] unmapped [4] = '{12'h010, 12'h03C, 12'h048, 12'h3FC};

  ethHost #(
    .SyncStages (SyncStages)
  ) UUT (
    .ifpins       (ifpins),
    .rstN_i       (rstN),
    .stb_i        (stb),
    .cyc_i        (cyc),
    .we_i         (we),
    .adr_i        (adr),
    .sel_i        (sel),
    .dat_i        (datIn),
    .dat_o        (datOut),
    .ack_o        (ack),
    .err_o        (err),
    .int_o        (intr),
    .crs_i        (crs),
    .coll_i       (coll),
    .rxDv_i       (rxDv),
    .rxErr_i      (rxErr),
    .rxD_i        (rxD),
    .rxDvGated_o  (rxDvGated),
    .rxErrGated_o (rxErrGated),
    .rxDGated_o   (rxDGated)
  );

  tbEthChecker check (
    .ifpins      (ifpins),
    .rstN_i      (rstN),
    .stb_i       (stb),
    .cyc_i       (cyc),
    .we_i        (we),
    .adr_i       (adr),
    .sel_i       (sel),
    .dat_i       (datIn),
    .dat_o       (datOut),
    .ack_o       (ack),
    .err_o       (err),
    .expStatus_i (expStatus),
    .expIntSrc_i (expIntSrc),
    .errCount_o  (chkErrors)
  );

  initial
  begin
    ifpins = 1'b0;
    forever #2 ifpins = ~ifpins;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic byteSelT randLanes();
    byteSelT lanes;
    lanes = byteSelT'(randBits(4));
    // An all-clear select would be an error access
    if (lanes == '0)
      lanes = 4'b1000;
    return lanes;
  endfunction

  task automatic checkValue(input string what, input dataT expVal, input dataT actVal);
    if (actVal !== expVal)
    begin
      tbErrors++;
      $display("CHECK FAILED %s %s: expected %h, got %h", testName, what, expVal, actVal);
    end
  endtask

  // Host holds the request until ack or err, then drops it
  task automatic hostAccess(input logic isWrite, input logic [11:0] byteAdr,
                            input byteSelT lanes, input dataT wrData);
    int waited;
    @(negedge ifpins);
    stb    = 1'b1;
    cyc    = 1'b1;
    we     = isWrite;
    adr    = byteAdr[11:2];
    sel    = lanes;
    datIn  = wrData;
    waited = 0;
    while (!(ack || err) && waited < BusTimeout)
    begin
      @(negedge ifpins);
      waited++;
    end
    stb = 1'b0;
    cyc = 1'b0;
    we  = 1'b0;
    sel = '0;
    if (!(ack || err))
    begin
      tbErrors++;
      $display("Bus access timed out in %s: no ack or err came back from %h",
               testName, byteAdr);
    end
  endtask

  task automatic writeReg(input logic [11:0] byteAdr, input byteSelT lanes, input dataT d);
    hostAccess(1'b1, byteAdr, lanes, d);
  endtask

  task automatic readReg(input logic [11:0] byteAdr);
    hostAccess(1'b0, byteAdr, 4'hF, '0);
  endtask

  // Carrier and collision pins held until synchronized
  task automatic holdPins(input logic c, input logic k);
    @(negedge ifpins);
    crs  = c;
    coll = k;
    repeat (SyncStages + 2) @(negedge ifpins);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rstN      = 1'b0;
    stb       = 1'b0;
    cyc       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    sel       = '0;
    datIn     = '0;
    crs       = 1'b0;
    coll      = 1'b0;
    // Raw receive pins start high so the cleared enable has to gate them
    rxDv      = 1'b1;
    rxErr     = 1'b1;
    rxD       = '0;
    expStatus = '0;
    expIntSrc = '0;
    repeat (4) @(negedge ifpins);
    rstN = 1'b1;
    @(negedge ifpins);

    // Everything idle and cleared
    testName = "after reset";
    checkValue("ack_o", '0, dataT'(ack));
    checkValue("err_o", '0, dataT'(err));
    checkValue("int_o", '0, dataT'(intr));
    checkValue("rxDvGated_o", '0, dataT'(rxDvGated));
    checkValue("rxErrGated_o", '0, dataT'(rxErrGated));
    rxDv  = 1'b0;
    rxErr = 1'b0;
    readReg(ModerAdr);
    readReg(IntSourceAdr);
    readReg(IntMaskAdr);
    readReg(StatusAdr);
    readReg(MacAddr0Adr);
    readReg(MacAddr1Adr);

    // Random lanes with each write read back by the checker
    testName = "byte lanes";
    for (int r = 0; r < 4; r++)
    begin
      for (int n = 0; n < 4; n++)
      begin
        writeReg(laneRegs[r], randLanes(), randBits(32));
        readReg(laneRegs[r]);
      end
    end
    for (int u = 0; u < 4; u++)
    begin
      writeReg(unmapped[u], randLanes(), randBits(32));
      readReg(unmapped[u]);
    end
    // STATUS ignores the write and shows receive enable only
    writeReg(ModerAdr, 4'hF, 32'h1);
    writeReg(StatusAdr, randLanes(), randBits(32));
    expStatus = 32'h4;
    readReg(StatusAdr);

    testName = "error response";
    readReg(12'h400);
    writeReg(12'h7FC, 4'hF, randBits(32));
    writeReg(12'h800, 4'hF, randBits(32));
    readReg(12'hFFC);
    for (int n = 0; n < 4; n++)
    begin
      errAdr = 12'(randBits(12)) | 12'h400;
      writeReg(errAdr, randLanes(), randBits(32));
      readReg(errAdr);
    end
    // No lane selected
    writeReg(ModerAdr, 4'h0, randBits(32));
    writeReg(MacAddr0Adr, 4'h0, randBits(32));
    hostAccess(1'b0, IntMaskAdr, 4'h0, '0);
    for (int r = 0; r < 4; r++)
      readReg(laneRegs[r]);

    testName = "rx gating";
    writeReg(ModerAdr, 4'hF, 32'h1);
    repeat (2) @(negedge ifpins);
    rxDv  = 1'b1;
    rxErr = 1'b1;
    rxD   = nibbleT'(randBits(4));
    @(negedge ifpins);
    checkValue("rxDvGated_o", 32'h1, dataT'(rxDvGated));
    checkValue("rxErrGated_o", 32'h1, dataT'(rxErrGated));
    checkValue("rxDGated_o", dataT'(rxD), dataT'(rxDGated));
    rxErr = 1'b0;
    @(negedge ifpins);
    checkValue("rxErrGated_o low", '0, dataT'(rxErrGated));
    // Clearing RxEn mid frame must not cut the frame
    writeReg(ModerAdr, 4'hF, 32'h0);
    repeat (2) @(negedge ifpins);
    checkValue("rxDvGated_o held", 32'h1, dataT'(rxDvGated));
    rxDv = 1'b0;
    @(negedge ifpins);
    checkValue("rxDvGated_o end", '0, dataT'(rxDvGated));
    rxDv  = 1'b1;
    rxErr = 1'b1;
    @(negedge ifpins);
    checkValue("rxDvGated_o off", '0, dataT'(rxDvGated));
    checkValue("rxErrGated_o off", '0, dataT'(rxErrGated));
    rxDv  = 1'b0;
    rxErr = 1'b0;

    // Half duplex first and then FullD masks both
    testName = "status sync";
    holdPins(1'b1, 1'b0);
    expStatus = 32'h1;
    readReg(StatusAdr);
    holdPins(1'b0, 1'b1);
    expStatus = 32'h2;
    readReg(StatusAdr);
    holdPins(1'b1, 1'b1);
    expStatus = 32'h3;
    readReg(StatusAdr);
    writeReg(ModerAdr, 4'hF, 32'h400);
    expStatus = 32'h0;
    readReg(StatusAdr);
    writeReg(ModerAdr, 4'hF, 32'h0);

    testName = "interrupts";
    holdPins(1'b0, 1'b0);
    writeReg(IntSourceAdr, 4'hF, 32'h3);
    expIntSrc = 32'h0;
    readReg(IntSourceAdr);
    writeReg(IntMaskAdr, 4'hF, 32'h3);
    checkValue("int_o idle", '0, dataT'(intr));
    holdPins(1'b0, 1'b1);
    expIntSrc = 32'h1;
    checkValue("int_o collision", 32'h1, dataT'(intr));
    readReg(IntSourceAdr);
    // Frame start through the gated data valid
    writeReg(ModerAdr, 4'hF, 32'h1);
    repeat (2) @(negedge ifpins);
    rxDv = 1'b1;
    repeat (2) @(negedge ifpins);
    rxDv = 1'b0;
    expIntSrc = 32'h3;
    readReg(IntSourceAdr);
    writeReg(IntSourceAdr, 4'hF, 32'h1);
    expIntSrc = 32'h2;
    readReg(IntSourceAdr);
    checkValue("int_o frame left", 32'h1, dataT'(intr));
    writeReg(IntSourceAdr, 4'hF, 32'h2);
    expIntSrc = 32'h0;
    readReg(IntSourceAdr);
    checkValue("int_o cleared", '0, dataT'(intr));
    // Collision source masked off
    writeReg(IntMaskAdr, 4'hF, 32'h2);
    holdPins(1'b0, 1'b0);
    holdPins(1'b0, 1'b1);
    expIntSrc = 32'h1;
    checkValue("int_o masked", '0, dataT'(intr));
    readReg(IntSourceAdr);

    repeat (3) @(negedge ifpins);
    $display("Errors: checker %0d, testbench %0d", chkErrors, tbErrors);
    if (chkErrors == 0 && tbErrors == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tbEthChecker.sv ====
/*
 * Bus response checker for the Ethernet MAC host glue
 * Shadows the host registers and compares every ack, err and read
 */

`timescale 1ns/1ps

module tbEthChecker (
  input  logic             ifpins,
  input  logic             rstN_i,
  input  logic             stb_i,
  input  logic             cyc_i,
  input  logic             we_i,
  input  ethPkg::wordAddrT adr_i,
  input  ethPkg::byteSelT  sel_i,
  input  ethPkg::dataT     dat_i,
  input  ethPkg::dataT     dat_o,
  input  logic             ack_o,
  input  logic             err_o,
  input  ethPkg::dataT     expStatus_i,
  input  ethPkg::dataT     expIntSrc_i,
  output int               errCount_o
);

  import ethPkg::*;

  // Shadow copies of the host writable registers
  dataT shModer;
  dataT shIntMask;
  dataT shMac0;
  dataT shMac1;

  // Request seen at the last rising edge and what it owes
  logic pending = 1'b0;
  logic regAccess;
  logic expAck;
  logic expErr;
  logic expRead;
  dataT expData;

  int errCount = 0;

  assign errCount_o = errCount;

  // Old value with the selected byte lanes replaced
  function automatic dataT laneWrite(input dataT old, input dataT wr, input byteSelT lanes);
    dataT keep;
    keep = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    return (old & ~keep) | (wr & keep);
  endfunction

  // Reference read value for a register index
  function automatic dataT refRead(input regIdxT idx);
    case (idx)
      ModerIdx:     return shModer;
      IntSourceIdx: return expIntSrc_i;
      IntMaskIdx:   return shIntMask;
      StatusIdx:    return expStatus_i;
      MacAddr0Idx:  return shMac0;
      MacAddr1Idx:  return shMac1;
      default:      return '0;
    endcase
  endfunction

  task automatic compareValue(input string what, input dataT expVal, input dataT actVal);
    if (actVal !== expVal)
    begin
      errCount++;
      $display("CHECK FAILED %s %s: expected %h, got %h",
               tbEth.testName, what, expVal, actVal);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Request snooping at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge ifpins)
  begin
    if (!rstN_i)
    begin
      shModer   = '0;
      shIntMask = '0;
      shMac0    = '0;
      shMac1    = '0;
      pending   = 1'b0;
    end
    else
    begin
      // A held request only counts every other edge
      pending = stb_i & cyc_i & ~pending;
      if (pending)
      begin
        // Registers live below 0x400 and need a lane
        regAccess = (sel_i != '0) && (adr_i[11:10] == 2'b00);
        expAck    = regAccess;
        expErr    = ~regAccess;
        expRead   = regAccess & ~we_i;
        expData   = refRead(adr_i[9:2]);
        if (regAccess && we_i)
        begin
          case (adr_i[9:2])
            ModerIdx:    shModer   = laneWrite(shModer, dat_i, sel_i) & ModerMask;
            IntMaskIdx:  shIntMask = laneWrite(shIntMask, dat_i, sel_i) & IntBitsMask;
            MacAddr0Idx: shMac0    = laneWrite(shMac0, dat_i, sel_i);
            MacAddr1Idx: shMac1    = laneWrite(shMac1, dat_i, sel_i) & MacAddr1Mask;
            default:     ;
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response compare in mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge ifpins)
  begin
    if (rstN_i)
    begin
      if (pending)
      begin
        compareValue("ack_o", dataT'(expAck), dataT'(ack_o));
        compareValue("err_o", dataT'(expErr), dataT'(err_o));
        if (expRead)
          compareValue("dat_o", expData, dat_o);
      end
      else if (ack_o || err_o)
      begin
        errCount++;
        $display("Bus response seen with no request pending at %0t", $time);
      end
    end
  end

endmodule
